//--- axi_wr_xbar.f
hdl/axi_pkg.sv
hdl/aw_arbiter.sv
hdl/aw_router.sv
hdl/b_router.sv
hdl/axi_wr_xbar.sv
tb/axi_wr_xbar_tb.sv

//--- hdl/aw_arbiter.sv
`timescale 1ns/1ps

module aw_arbiter
  import axi_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  aw_req_t                m_aw      [NUM_MASTERS],
  input  logic [NUM_MASTERS-1:0] m_awvalid,
  output logic [NUM_MASTERS-1:0] m_awready,
  output aws_req_t               gnt_aw,
  output logic                   gnt_valid,
  input  logic                   gnt_ready,
  input  logic [NUM_MASTERS-1:0] b_done
);

  grant_state_t           state;
  mst_idx_t               rr_ptr;
  mst_idx_t               held_idx;
  mst_idx_t               pick_idx;
  mst_idx_t               sel_idx;
  logic                   pick_found;
  logic                   aw_hs;
  logic [NUM_MASTERS-1:0] lock;
  logic [NUM_MASTERS-1:0] req;

  // Locked masters wait for their response
  assign req = m_awvalid & ~lock;

  // Round-robin search starting after the last winner
  always_comb begin
    int idx;
    pick_found = 1'b0;
    pick_idx   = rr_ptr;
    for (int k = 1; k <= NUM_MASTERS; k++) begin
      idx = (int'(rr_ptr) + k) % NUM_MASTERS;
      if (!pick_found && req[idx]) begin
        pick_found = 1'b1;
        pick_idx   = mst_idx_t'(idx);
      end
    end
  end

  assign sel_idx   = (state == GRANT_HELD) ? held_idx : pick_idx;
  assign gnt_valid = (state == GRANT_HELD) ? req[held_idx] : pick_found;
  assign aw_hs     = gnt_valid & gnt_ready;

  always_comb begin
    gnt_aw.id    = {sel_idx, m_aw[sel_idx].id};
    gnt_aw.addr  = m_aw[sel_idx].addr;
    gnt_aw.len   = m_aw[sel_idx].len;
    gnt_aw.size  = m_aw[sel_idx].size;
    gnt_aw.burst = m_aw[sel_idx].burst;
  end

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_awready[i] = aw_hs && (sel_idx == mst_idx_t'(i));
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state    <= GRANT_FREE;
      rr_ptr   <= '0;
      held_idx <= '0;
      lock     <= '0;
    end else begin
      // Clear on response, set on address handshake
      lock <= lock & ~b_done;
      if (aw_hs) begin
        lock[sel_idx] <= 1'b1;
        rr_ptr        <= sel_idx;
      end
      case (state)
        GRANT_FREE: begin
          if (pick_found && !gnt_ready) begin
            state    <= GRANT_HELD;
            held_idx <= pick_idx;
          end
        end
        GRANT_HELD: begin
          if (aw_hs) begin
            state <= GRANT_FREE;
          end
        end
        default: state <= GRANT_FREE;
      endcase
    end
  end

  // Stalled grant keeps its master and payload
  a_grant_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (gnt_valid && !gnt_ready) |=> $stable(gnt_aw)
  ) else $error("gnt_aw changed while stalled");

  a_bdone_locked: assert property (
    @(posedge clk) disable iff (!rstn)
    (b_done & ~lock) == '0
  ) else $error("b_done for a master with no write outstanding");

endmodule

//--- hdl/aw_router.sv
`timescale 1ns/1ps

module aw_router
  import axi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  aws_req_t              gnt_aw,
  input  logic                  gnt_valid,
  output logic                  gnt_ready,
  output aws_req_t              s_aw      [NUM_SLAVES],
  output logic [NUM_SLAVES-1:0] s_awvalid,
  input  logic [NUM_SLAVES-1:0] s_awready
);

  slv_sel_t slv_sel;

  assign slv_sel = addr_decode(gnt_aw.addr);

  // Only the addressed slave sees the request
  always_comb begin
    for (int j = 0; j < NUM_SLAVES; j++) begin
      s_aw[j]      = slv_sel[j] ? gnt_aw : '0;
      s_awvalid[j] = gnt_valid & slv_sel[j];
    end
  end

  assign gnt_ready = |(slv_sel & s_awready);

  a_aw_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0(s_awvalid)
  ) else $error("s_awvalid routed to more than one slave");

  // A stalled request stays at the same slave
  a_aw_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    ((s_awvalid & ~s_awready) != '0) |=> $stable(s_awvalid)
  ) else $error("s_awvalid moved before the handshake");

endmodule

//--- hdl/axi_pkg.sv
package axi_pkg;

  // Counts
  localparam int NUM_MASTERS = 3;
  localparam int NUM_SLAVES  = 7;

  // Channel field widths
  localparam int ID_BITS    = 4;
  localparam int MIDX_BITS  = 2;
  localparam int IDS_BITS   = ID_BITS + MIDX_BITS;
  localparam int ADDR_BITS  = 32;
  localparam int LEN_BITS   = 8;
  localparam int SIZE_BITS  = 3;
  localparam int BURST_BITS = 2;
  localparam int RESP_BITS  = 2;

  // Slave field in the address
  localparam int SLAVE_SEL_LSB  = 28;
  localparam int SLAVE_SEL_BITS = 3;

  typedef logic [ID_BITS-1:0]    axi_id_t;
  typedef logic [IDS_BITS-1:0]   axi_ids_t;
  typedef logic [ADDR_BITS-1:0]  axi_addr_t;
  typedef logic [MIDX_BITS-1:0]  mst_idx_t;
  typedef logic [NUM_SLAVES-1:0] slv_sel_t;

  // Write address as sent by a master
  typedef struct packed {
    axi_id_t                id;
    axi_addr_t              addr;
    logic [LEN_BITS-1:0]    len;
    logic [SIZE_BITS-1:0]   size;
    logic [BURST_BITS-1:0]  burst;
  } aw_req_t;

  // Write address at a slave with the master index in the ID
  typedef struct packed {
    axi_ids_t               id;
    axi_addr_t              addr;
    logic [LEN_BITS-1:0]    len;
    logic [SIZE_BITS-1:0]   size;
    logic [BURST_BITS-1:0]  burst;
  } aws_req_t;

  typedef struct packed {
    axi_id_t               id;
    logic [RESP_BITS-1:0]  resp;
  } b_rsp_t;

  typedef struct packed {
    axi_ids_t              id;
    logic [RESP_BITS-1:0]  resp;
  } bs_rsp_t;

  typedef enum logic {
    GRANT_FREE,
    GRANT_HELD
  } grant_state_t;

  // Unmapped field value lands on the default slave
  function automatic slv_sel_t addr_decode(input axi_addr_t addr);
    logic [SLAVE_SEL_BITS-1:0] field;
    slv_sel_t                  sel;
    field = addr[SLAVE_SEL_LSB +: SLAVE_SEL_BITS];
    sel   = '0;
    if (int'(field) < NUM_SLAVES) begin
      sel[field] = 1'b1;
    end else begin
      sel[NUM_SLAVES-1] = 1'b1;
    end
    return sel;
  endfunction

endpackage

//--- hdl/axi_wr_xbar.sv
`timescale 1ns/1ps

module axi_wr_xbar
  import axi_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  // Master side
  input  aw_req_t                m_aw      [NUM_MASTERS],
  input  logic [NUM_MASTERS-1:0] m_awvalid,
  output logic [NUM_MASTERS-1:0] m_awready,
  output b_rsp_t                 m_b       [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0] m_bvalid,
  input  logic [NUM_MASTERS-1:0] m_bready,
  // Slave side
  output aws_req_t               s_aw      [NUM_SLAVES],
  output logic [NUM_SLAVES-1:0]  s_awvalid,
  input  logic [NUM_SLAVES-1:0]  s_awready,
  input  bs_rsp_t                s_b       [NUM_SLAVES],
  input  logic [NUM_SLAVES-1:0]  s_bvalid,
  output logic [NUM_SLAVES-1:0]  s_bready
);

  aws_req_t               gnt_aw;
  logic                   gnt_valid;
  logic                   gnt_ready;
  logic [NUM_MASTERS-1:0] b_done;

  aw_arbiter u_aw_arbiter (
    .clk       (clk),
    .rstn      (rstn),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .gnt_aw    (gnt_aw),
    .gnt_valid (gnt_valid),
    .gnt_ready (gnt_ready),
    .b_done    (b_done)
  );

  aw_router u_aw_router (
    .clk       (clk),
    .rstn      (rstn),
    .gnt_aw    (gnt_aw),
    .gnt_valid (gnt_valid),
    .gnt_ready (gnt_ready),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready)
  );

  // Response completion releases the master lock
  b_router u_b_router (
    .clk      (clk),
    .rstn     (rstn),
    .s_b      (s_b),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .m_b      (m_b),
    .m_bvalid (m_bvalid),
    .m_bready (m_bready),
    .b_done   (b_done)
  );

endmodule

//--- hdl/b_router.sv
`timescale 1ns/1ps

module b_router
  import axi_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  bs_rsp_t                s_b      [NUM_SLAVES],
  input  logic [NUM_SLAVES-1:0]  s_bvalid,
  output logic [NUM_SLAVES-1:0]  s_bready,
  output b_rsp_t                 m_b      [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0] m_bvalid,
  input  logic [NUM_MASTERS-1:0] m_bready,
  output logic [NUM_MASTERS-1:0] b_done
);

  slv_sel_t low_sel;
  slv_sel_t pick;
  slv_sel_t hold_sel;
  logic     hold;
  bs_rsp_t  rsp;
  mst_idx_t dst;
  logic     rsp_valid;
  logic     rsp_ready;

  // Lowest responding slave wins
  assign low_sel = s_bvalid & (~s_bvalid + slv_sel_t'(1));

  // A stalled response keeps its slave until the handshake
  assign pick      = hold ? hold_sel : low_sel;
  assign rsp_valid = |(pick & s_bvalid);

  always_comb begin
    rsp = '0;
    for (int j = 0; j < NUM_SLAVES; j++) begin
      if (pick[j]) begin
        rsp = s_b[j];
      end
    end
  end

  // Master index sits in the top ID bits
  assign dst = rsp.id[IDS_BITS-1 -: MIDX_BITS];

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_bvalid[i] = rsp_valid && (dst == mst_idx_t'(i));
      m_b[i]      = '0;
      if (m_bvalid[i]) begin
        m_b[i].id   = rsp.id[ID_BITS-1:0];
        m_b[i].resp = rsp.resp;
      end
    end
  end

  assign b_done    = m_bvalid & m_bready;
  assign rsp_ready = |b_done;
  assign s_bready  = pick & {NUM_SLAVES{rsp_ready}};

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      hold     <= 1'b0;
      hold_sel <= '0;
    end else if (rsp_valid && !rsp_ready) begin
      hold     <= 1'b1;
      hold_sel <= pick;
    end else if (rsp_ready) begin
      hold <= 1'b0;
    end
  end

  a_b_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0(m_bvalid)
  ) else $error("m_bvalid raised for more than one master");

  a_b_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (rsp_valid && !rsp_ready) |=> ($stable(m_bvalid) && $stable(rsp))
  ) else $error("response changed under back-pressure");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI write crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module axi_wr_xbar_tb -f axi_wr_xbar.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vaxi_wr_xbar_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- tb/aw_patterns.txt
# master id addr len size burst slave_ready_delay resp, all hex
# addr[30:28] selects the slave, 7 goes to slave 6
0 1 00001000 03 2 1 0 0
1 2 10000040 00 2 1 1 0
2 3 20000080 07 3 1 0 1
0 4 30002000 0f 2 1 2 0
1 5 40000100 01 1 0 0 2
2 6 50000200 03 2 2 3 0
0 7 60000300 00 0 1 0 0
1 8 70000400 1f 2 1 1 3
2 9 f0000010 03 2 1 0 0
0 a 80000020 07 2 1 4 1
1 b 90000030 00 2 0 0 0
2 c a0000040 01 3 1 2 0
0 d b0000050 0f 1 1 1 2
1 e c0000060 03 2 2 0 0
2 f d0000070 07 2 1 3 0
0 0 e0000080 00 2 1 0 3
1 1 10001000 ff 2 1 2 0
2 2 10002000 03 2 1 0 0
0 3 10003000 01 2 1 1 0
1 4 60010000 07 2 1 0 1
2 5 60020000 0f 3 1 4 0
0 6 70030000 03 2 1 0 0
1 7 00000004 00 2 1 1 2
2 8 00000008 00 2 1 0 0
0 9 2000000c 03 2 1 2 0
1 a 30000010 07 1 1 0 0
2 b 40000014 01 2 0 1 3
0 c 50000018 03 2 1 0 0
1 d 5000001c 0f 2 2 3 0
2 e 60000020 07 2 1 0 1
0 f f8000000 00 2 1 1 0
1 0 80000024 03 2 1 0 0
2 1 c0000028 01 2 1 2 2
0 2 3000002c 07 3 1 0 0
1 3 40000030 03 2 1 1 0
2 4 e0000034 0f 2 1 0 0

//--- tb/axi_wr_xbar_tb.sv
`timescale 1ns/1ps

module axi_wr_xbar_tb
  import axi_pkg::*;
();

  logic                   clk;
  logic                   rstn;
  aw_req_t                m_aw      [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] m_awvalid;
  logic [NUM_MASTERS-1:0] m_awready;
  b_rsp_t                 m_b       [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] m_bvalid;
  logic [NUM_MASTERS-1:0] m_bready;
  aws_req_t               s_aw      [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  s_awvalid;
  logic [NUM_SLAVES-1:0]  s_awready;
  bs_rsp_t                s_b       [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  s_bvalid;
  logic [NUM_SLAVES-1:0]  s_bready;

  // One pattern entry per transaction
  int          p_mst[$];
  int          p_id[$];
  logic [31:0] p_addr[$];
  int          p_len[$];
  int          p_size[$];
  int          p_burst[$];
  int          p_dly[$];
  int          p_resp[$];
  int          n_pat;

  // Master, slave and arbitration models
  int                    pend[NUM_MASTERS];
  int                    outst[NUM_MASTERS];
  int                    rsp_slv[NUM_MASTERS];
  int                    rsp_wait[NUM_MASTERS];
  axi_ids_t              rsp_id[NUM_MASTERS];
  int                    b_mst[NUM_SLAVES];
  int                    aw_cnt[NUM_SLAVES];
  logic [NUM_SLAVES-1:0] aw_rdy;
  int                    last_win;
  int                    held_m;
  int                    stall_slv;
  aws_req_t              stall_req;
  int                    b_stall;
  int                    done_cnt;
  int                    mism_cnt;
  int                    fail_cnt;

  axi_wr_xbar uut (
    .clk       (clk),
    .rstn      (rstn),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_b       (m_b),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_b       (s_b),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready)
  );

  always #20 clk = ~clk;

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      mism_cnt++;
      $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    end
  endtask

  // Field 7 of addr[30:28] is unmapped and lands on the last slave
  function automatic int slave_of(input logic [31:0] addr);
    int field;
    field = int'(addr[30:28]);
    return (field == 7) ? 6 : field;
  endfunction

  function automatic int next_txn(input int m, input int from);
    for (int i = from; i < n_pat; i++) begin
      if (p_mst[i] == m) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    int          mst;
    int          id;
    int          len;
    int          size;
    int          burst;
    int          dly;
    int          resp;
    logic [31:0] addr;
    fd = $fopen("tb/aw_patterns.txt", "r");
    if (fd == 0) begin
      fail_cnt++;
      $display("Could not open the pattern file tb/aw_patterns.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", mst, id, addr, len, size, burst, dly, resp);
        if (n == 8) begin
          p_mst.push_back(mst);
          p_id.push_back(id);
          p_addr.push_back(addr);
          p_len.push_back(len);
          p_size.push_back(size);
          p_burst.push_back(burst);
          p_dly.push_back(dly);
          p_resp.push_back(resp);
        end
      end
    end
    $fclose(fd);
    n_pat = p_mst.size();
    if (n_pat == 0) begin
      fail_cnt++;
      $display("The pattern file holds no transactions");
    end
  endtask

  task automatic drive_cycle();
    int i;
    int m;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      i = pend[k];
      m_awvalid[k] = (i >= 0);
      m_aw[k]      = '0;
      if (i >= 0) begin
        m_aw[k].id    = axi_id_t'(p_id[i]);
        m_aw[k].addr  = p_addr[i];
        m_aw[k].len   = 8'(p_len[i]);
        m_aw[k].size  = 3'(p_size[i]);
        m_aw[k].burst = 2'(p_burst[i]);
      end
      m_bready[k] = ($urandom % 4) != 0;
    end
    s_awready = aw_rdy;
    // A slave with a zero-delay request waiting is ready at once
    for (int k = 0; k < NUM_MASTERS; k++) begin
      i = pend[k];
      if (i >= 0 && p_dly[i] == 0) begin
        s_awready[slave_of(p_addr[i])] = 1'b1;
      end
    end
    for (int j = 0; j < NUM_SLAVES; j++) begin
      m = b_mst[j];
      s_bvalid[j] = (m >= 0);
      s_b[j]      = '0;
      if (m >= 0) begin
        s_b[j].id   = rsp_id[m];
        s_b[j].resp = 2'(p_resp[outst[m]]);
      end
    end
  endtask

  task automatic sample_cycle();
    logic [NUM_MASTERS-1:0] locked;
    logic [NUM_MASTERS-1:0] exp_rdy;
    aws_req_t               req;
    int                     exp_m;
    int                     exp_j;
    int                     act_j;
    int                     i;
    int                     m;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      locked[k] = (outst[k] >= 0);
    end

    // Lowest responding slave wins unless one is stalled
    exp_j = b_stall;
    for (int j = NUM_SLAVES - 1; j >= 0; j--) begin
      if (b_stall < 0 && b_mst[j] >= 0) begin
        exp_j = j;
      end
    end
    if (exp_j < 0) begin
      check("m_bvalid", 64'(0), 64'(m_bvalid));
      check("s_bready", 64'(0), 64'(s_bready));
    end else begin
      m = b_mst[exp_j];
      i = outst[m];
      check("m_bvalid", 64'(1 << m), 64'(m_bvalid));
      check($sformatf("m_b[%0d].id", m), 64'(p_id[i]), 64'(m_b[m].id));
      check($sformatf("m_b[%0d].resp", m), 64'(p_resp[i]), 64'(m_b[m].resp));
      check("s_bready", m_bready[m] ? 64'(1 << exp_j) : 64'(0), 64'(s_bready));
      if (m_bready[m]) begin
        outst[m]     = -1;
        b_mst[exp_j] = -1;
        b_stall      = -1;
        done_cnt++;
      end else begin
        b_stall = exp_j;
      end
    end
    for (int k = 0; k < NUM_MASTERS; k++) begin
      if (outst[k] >= 0 && rsp_wait[k] > 0) begin
        rsp_wait[k]--;
      end
      if (outst[k] >= 0 && rsp_wait[k] == 0 && b_mst[rsp_slv[k]] < 0) begin
        b_mst[rsp_slv[k]] = k;
        rsp_wait[k]       = -1;
      end
    end

    // A held grant goes before the rotation after the last winner
    exp_m = held_m;
    for (int k = 1; k <= NUM_MASTERS; k++) begin
      m = (last_win + k) % NUM_MASTERS;
      if (exp_m < 0 && pend[m] >= 0 && !locked[m]) begin
        exp_m = m;
      end
    end
    act_j = -1;
    for (int j = 0; j < NUM_SLAVES; j++) begin
      if (s_awvalid[j]) begin
        act_j = j;
      end
    end
    check("s_awvalid ones", 64'(act_j >= 0), 64'($countones(s_awvalid)));
    exp_rdy = '0;
    if (exp_m < 0) begin
      check("s_awvalid", 64'(0), 64'(s_awvalid));
    end else begin
      i = pend[exp_m];
      check("aw slave index", 64'(slave_of(p_addr[i])), 64'(act_j));
      if (act_j >= 0) begin
        req = s_aw[act_j];
        check("s_aw.id", 64'({mst_idx_t'(exp_m), axi_id_t'(p_id[i])}), 64'(req.id));
        check("s_aw.addr", 64'(p_addr[i]), 64'(req.addr));
        check("s_aw.len", 64'(p_len[i]), 64'(req.len));
        check("s_aw.size", 64'(p_size[i]), 64'(req.size));
        check("s_aw.burst", 64'(p_burst[i]), 64'(req.burst));
        if (stall_slv >= 0) begin
          check("stalled s_aw", 64'(stall_req), 64'(req));
          check("stalled slave index", 64'(stall_slv), 64'(act_j));
        end
        if (s_awready[act_j]) begin
          exp_rdy[exp_m]  = 1'b1;
          outst[exp_m]    = i;
          rsp_id[exp_m]   = req.id;
          rsp_slv[exp_m]  = act_j;
          rsp_wait[exp_m] = 1 + int'($urandom % 8);
          pend[exp_m]     = next_txn(exp_m, i + 1);
          last_win        = exp_m;
          held_m          = -1;
          stall_slv       = -1;
          aw_cnt[act_j]   = 0;
          aw_rdy[act_j]   = 1'b0;
        end else begin
          held_m    = exp_m;
          stall_slv = act_j;
          stall_req = req;
          aw_cnt[act_j]++;
          if (aw_cnt[act_j] >= p_dly[i]) begin
            aw_rdy[act_j] = 1'b1;
          end
        end
      end
    end
    check("m_awready", 64'(exp_rdy), 64'(m_awready));
  endtask

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    m_awvalid = '0;
    m_bready  = '0;
    s_awready = '0;
    s_bvalid  = '0;
    aw_rdy    = '0;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      m_aw[k]     = '0;
      pend[k]     = -1;
      outst[k]    = -1;
      rsp_slv[k]  = 0;
      rsp_wait[k] = -1;
      rsp_id[k]   = '0;
    end
    for (int j = 0; j < NUM_SLAVES; j++) begin
      s_b[j]    = '0;
      b_mst[j]  = -1;
      aw_cnt[j] = 0;
    end
    last_win  = 0;
    held_m    = -1;
    stall_slv = -1;
    stall_req = '0;
    b_stall   = -1;
    done_cnt  = 0;
    mism_cnt  = 0;
    fail_cnt  = 0;
    void'($urandom(32'h332b90c4));
    load_patterns();
    repeat (8) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(negedge clk);
    check("s_awvalid after reset", 64'(0), 64'(s_awvalid));
    check("m_bvalid after reset", 64'(0), 64'(m_bvalid));
    for (int k = 0; k < NUM_MASTERS; k++) begin
      pend[k] = next_txn(k, 0);
    end
    while (done_cnt < n_pat) begin
      @(posedge clk);
      #2;
      drive_cycle();
      @(negedge clk);
      sample_cycle();
    end
    $display("Done %0d of %0d writes, %0d mismatches, %0d other errors",
             done_cnt, n_pat, mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Budget of 200 cycles per transaction
  initial begin
    wait (n_pat > 0);
    repeat (n_pat * 200) @(posedge clk);
    fail_cnt++;
    $display("Watchdog expired before all write responses came back");
    $display("Done %0d of %0d writes, %0d mismatches, %0d other errors",
             done_cnt, n_pat, mism_cnt, fail_cnt);
    $display("Result: FAILED");
    $finish;
  end

endmodule
